// ==== lsu_bus_pkg.sv ====
package lsu_bus_pkg;

  localparam int sq_size  = 4;
  localparam int sq_ptr_w = $clog2(sq_size);
  localparam int l1d_len  = 4;
  localparam int l1d_size = 1 << l1d_len;
  localparam int tag_w    = 32 - l1d_len - 2;

  // address map, limits exclusive
  localparam logic [31:0] sram_base  = 32'h0f00_0000;  // cacheable
  localparam logic [31:0] sram_limit = 32'h0f00_2000;
  localparam logic [31:0] dev_base   = 32'h1000_0000;  // uncacheable
  localparam logic [31:0] dev_limit  = 32'h1000_1000;

  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
    logic [3:0]  rstrb;
  } bus_rd_req_t;

  typedef struct packed {
    logic        wvalid;
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_wr_req_t;

  // rdata is the whole word at araddr[31:2]
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        wready;
  } bus_rsp_t;

endpackage

// ==== lsu_op_pkg.sv ====
package lsu_op_pkg;

  localparam int xlen = 32;

  // funct3 style, upper bits zero
  typedef enum logic [4:0] {
    lb  = 5'd0,
    lh  = 5'd1,
    lw  = 5'd2,
    lbu = 5'd4,
    lhu = 5'd5
  } load_kind_t;

  typedef struct packed {
    load_kind_t kind;
  } load_op_t;

  typedef struct packed {
    logic       spare;
    logic [3:0] wstrb;  // byte lanes of the word
  } store_op_t;

  typedef union packed {
    load_op_t  ld;
    store_op_t st;
  } lsu_op_u;

  typedef struct packed {
    logic            ren;
    logic [xlen-1:0] addr;
    lsu_op_u         op;
  } load_req_t;

  typedef struct packed {
    logic            rvalid;
    logic [xlen-1:0] rdata;
  } load_rsp_t;

  // data sits in its byte lanes, as selected by op.st.wstrb
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    lsu_op_u         op;
  } store_req_t;

  typedef struct packed {
    logic [xlen-1:0]                 addr;
    load_kind_t                      kind;
    logic [3:0]                      rstrb;
    logic                            valid_region;
    logic                            uncacheable;
    logic [lsu_bus_pkg::tag_w-1:0]   tag;
    logic [lsu_bus_pkg::l1d_len-1:0] idx;
  } load_info_t;

  // bytes touched by a load, before the offset shift
  function automatic logic [3:0] kind_strobe(load_kind_t kind);
    case (kind)
      lb, lbu: return 4'b0001;
      lh, lhu: return 4'b0011;
      lw:      return 4'b1111;
      default: return 4'b0000;
    endcase
  endfunction

endpackage

// ==== lsu_decode.sv ====
`timescale 1ns/1ns

module lsu_decode (
  input  lsu_op_pkg::load_req_t  load_req,
  output lsu_op_pkg::load_info_t info
);
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  logic [xlen-1:0] addr;
  logic            in_sram;
  logic            in_dev;

  assign addr    = load_req.addr;
  assign in_sram = addr >= sram_base && addr < sram_limit;
  assign in_dev  = addr >= dev_base && addr < dev_limit;

  always_comb begin
    info.addr         = addr;
    info.kind         = load_req.op.ld.kind;
    info.rstrb        = kind_strobe(load_req.op.ld.kind);
    info.valid_region = in_sram || in_dev;
    info.uncacheable  = in_dev;  // device reads have side effects
    info.tag          = addr[xlen-1:l1d_len+2];
    info.idx          = addr[l1d_len+1:2];
  end

endmodule

// ==== lsu_store_queue.sv ====
`timescale 1ns/1ns

module lsu_store_queue (
  input                          clock,
  input                          reset,
  input  lsu_op_pkg::store_req_t commit,
  input  logic                   drain_done,
  input  logic [31:0]            load_addr,
  input  lsu_op_pkg::load_kind_t load_kind,
  output logic                   sq_ready,
  output logic                   empty,
  output lsu_op_pkg::store_req_t head,
  output logic                   fwd_hit,
  output logic [31:0]            fwd_data
);
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  store_req_t          entry[sq_size];
  logic [sq_size-1:0]  valid;
  logic [sq_ptr_w-1:0] head_ptr;
  logic [sq_ptr_w-1:0] tail_ptr;
  logic [3:0]          load_mask;
  logic                match;
  logic [sq_ptr_w-1:0] match_idx;

  assign sq_ready = !valid[tail_ptr];
  assign empty    = valid == '0;

  always_comb begin
    head       = entry[head_ptr];
    head.valid = valid[head_ptr];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= '0;
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (commit.valid && sq_ready) begin
        valid[tail_ptr] <= 1'b1;
        tail_ptr        <= tail_ptr + 1'b1;
      end
      if (drain_done) begin
        valid[head_ptr] <= 1'b0;
        head_ptr        <= head_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (commit.valid && sq_ready) begin
      entry[tail_ptr] <= commit;
    end
  end

  assign load_mask = kind_strobe(load_kind) << load_addr[1:0];

  // oldest to youngest, so the last match wins
  always_comb begin
    logic [sq_ptr_w-1:0] slot;
    match     = 1'b0;
    match_idx = head_ptr;
    for (int i = 0; i < sq_size; i++) begin
      slot = head_ptr + i[sq_ptr_w-1:0];
      if (valid[slot] && entry[slot].addr[31:2] == load_addr[31:2]) begin
        match     = 1'b1;
        match_idx = slot;
      end
    end
  end

  // a partial cover cannot forward, the load waits for the drain
  assign fwd_hit  = match && (entry[match_idx].op.st.wstrb & load_mask) == load_mask;
  assign fwd_data = entry[match_idx].data;  // already lane aligned

endmodule

// ==== lsu_l1d.sv ====
`timescale 1ns/1ns

module lsu_l1d (
  input                                   clock,
  input                                   reset,
  input                                   fence,
  input  logic [lsu_bus_pkg::tag_w-1:0]   lookup_tag,
  input  logic [lsu_bus_pkg::l1d_len-1:0] lookup_idx,
  input  logic                            wr_en,
  input  logic [lsu_bus_pkg::l1d_len-1:0] wr_idx,
  input  logic [lsu_bus_pkg::tag_w-1:0]   wr_tag,
  input  logic                            wr_valid,
  input  logic [31:0]                     wr_data,
  output logic                            hit,
  output logic [31:0]                     rd_data
);
  import lsu_bus_pkg::*;

  logic [tag_w-1:0]    tags[l1d_size];
  logic [31:0]         data[l1d_size];
  logic [l1d_size-1:0] valid;

  assign hit     = valid[lookup_idx] && tags[lookup_idx] == lookup_tag;
  assign rd_data = data[lookup_idx];

  // fill or full-word store
  always_ff @(posedge clock) begin
    if (wr_en && wr_valid) begin
      tags[wr_idx] <= wr_tag;
      data[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (fence) begin
      valid <= '0;
    end else if (wr_en) begin
      if (wr_valid) begin
        valid[wr_idx] <= 1'b1;
      end else if (tags[wr_idx] == wr_tag) begin
        valid[wr_idx] <= 1'b0;  // partial store hit, drop the line
      end
    end
  end

endmodule

// ==== lsu_execute.sv ====
`timescale 1ns/1ns

module lsu_execute (
  input                            clock,
  input                            reset,
  input                            flush,
  input                            fence,
  input  lsu_op_pkg::load_info_t   info,
  input  logic                     ren,
  input  lsu_op_pkg::store_req_t   store_in,
  input  lsu_bus_pkg::bus_rsp_t    bus_rsp,
  output logic                     sq_ready,
  output lsu_bus_pkg::bus_rd_req_t rd_req,
  output lsu_bus_pkg::bus_wr_req_t wr_req,
  output logic [31:0]              raw_data,
  output logic                     done
);
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  typedef enum logic [1:0] {ld_idle, ld_bus, ld_valid} ld_state_t;
  typedef enum logic {st_issue, st_recover} st_state_t;

  ld_state_t          ld_state;
  st_state_t          st_state;
  store_req_t         head;
  logic               sq_empty;
  logic               fwd_hit;
  logic [xlen-1:0]    fwd_data;
  logic               drain_done;
  logic               cache_hit;
  logic [xlen-1:0]    cache_data;
  logic [xlen-1:0]    rd_addr;  // held for the whole bus read
  logic [3:0]         rd_strb;
  logic               rd_cacheable;
  logic               rd_killed;  // flushed while the read was out
  logic               ld_fill;
  logic               wr_en;
  logic [l1d_len-1:0] wr_idx;
  logic [tag_w-1:0]   wr_tag;
  logic               wr_valid;
  logic [xlen-1:0]    wr_data;

  lsu_store_queue u_sq (
    .clock      (clock),
    .reset      (reset),
    .commit     (store_in),
    .drain_done (drain_done),
    .load_addr  (info.addr),
    .load_kind  (info.kind),
    .sq_ready   (sq_ready),
    .empty      (sq_empty),
    .head       (head),
    .fwd_hit    (fwd_hit),
    .fwd_data   (fwd_data)
  );

  lsu_l1d u_l1d (
    .clock      (clock),
    .reset      (reset),
    .fence      (fence),
    .lookup_tag (info.tag),
    .lookup_idx (info.idx),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_tag     (wr_tag),
    .wr_valid   (wr_valid),
    .wr_data    (wr_data),
    .hit        (cache_hit),
    .rd_data    (cache_data)
  );

  assign rd_req.arvalid = ld_state == ld_bus;
  assign rd_req.araddr  = rd_addr;
  assign rd_req.rstrb   = rd_strb;

  assign wr_req.wvalid = head.valid && st_state == st_issue;
  assign wr_req.waddr  = {head.addr[xlen-1:2], 2'b00};
  assign wr_req.wdata  = head.data;
  assign wr_req.wstrb  = head.op.st.wstrb;

  assign drain_done = wr_req.wvalid && bus_rsp.wready;
  assign ld_fill    = ld_state == ld_bus && bus_rsp.rvalid && rd_cacheable;
  assign done       = ld_state == ld_valid;

  // one write port, a store update beats a fill
  always_comb begin
    wr_en = drain_done || ld_fill;
    if (drain_done) begin
      wr_idx   = head.addr[l1d_len+1:2];
      wr_tag   = head.addr[xlen-1:l1d_len+2];
      wr_valid = head.op.st.wstrb == 4'hf;  // partial: invalidate on hit
      wr_data  = head.data;
    end else begin
      wr_idx   = rd_addr[l1d_len+1:2];
      wr_tag   = rd_addr[xlen-1:l1d_len+2];
      wr_valid = 1'b1;
      wr_data  = bus_rsp.rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ld_state  <= ld_idle;
      rd_killed <= 1'b0;
    end else begin
      case (ld_state)
        ld_idle: begin
          rd_killed <= 1'b0;
          if (ren && !flush) begin
            if (!info.valid_region || fwd_hit || (sq_empty && cache_hit)) begin
              ld_state <= ld_valid;
            end else if (sq_empty) begin
              ld_state <= ld_bus;
            end
          end
        end
        ld_bus: begin
          // a flushed read still completes on the bus, its data is dropped
          if (bus_rsp.rvalid) begin
            ld_state <= (rd_killed || flush) ? ld_idle : ld_valid;
          end else if (flush) begin
            rd_killed <= 1'b1;
          end
        end
        ld_valid: ld_state <= ld_idle;
        default:  ld_state <= ld_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ld_state == ld_idle) begin
      rd_addr      <= info.addr;
      rd_strb      <= info.rstrb;
      rd_cacheable <= !info.uncacheable;
      if (!info.valid_region) begin
        raw_data <= '0;
      end else if (fwd_hit) begin
        raw_data <= fwd_data;
      end else begin
        raw_data <= cache_data;
      end
    end else if (ld_state == ld_bus && bus_rsp.rvalid) begin
      raw_data <= bus_rsp.rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      st_state <= st_issue;
    end else begin
      case (st_state)
        st_issue: begin
          if (drain_done) begin
            st_state <= st_recover;
          end
        end
        default: st_state <= st_issue;  // one idle cycle after each write
      endcase
    end
  end

endmodule

// ==== lsu_result.sv ====
`timescale 1ns/1ns

module lsu_result (
  input  lsu_op_pkg::load_info_t info,
  input  logic [31:0]            raw_data,
  input  logic                   done,
  output lsu_op_pkg::load_rsp_t  load_rsp
);
  import lsu_op_pkg::*;

  logic [xlen-1:0] shifted;

  // byte offset down to lane 0
  assign shifted = raw_data >> {info.addr[1:0], 3'b000};

  always_comb begin
    load_rsp.rvalid = done;
    case (info.kind)
      lb:      load_rsp.rdata = {{24{shifted[7]}}, shifted[7:0]};
      lbu:     load_rsp.rdata = {24'b0, shifted[7:0]};
      lh:      load_rsp.rdata = {{16{shifted[15]}}, shifted[15:0]};
      lhu:     load_rsp.rdata = {16'b0, shifted[15:0]};
      lw:      load_rsp.rdata = shifted;
      default: load_rsp.rdata = '0;
    endcase
  end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
  input                            clock,
  input                            reset,
  input                            flush,
  input                            fence,
  input  lsu_op_pkg::load_req_t    load_req,
  input  lsu_op_pkg::store_req_t   store_req,
  input  lsu_bus_pkg::bus_rsp_t    bus_rsp,
  output lsu_op_pkg::load_rsp_t    load_rsp,
  output logic                     sq_ready,
  output lsu_bus_pkg::bus_rd_req_t bus_rd_req,
  output lsu_bus_pkg::bus_wr_req_t bus_wr_req
);
  import lsu_op_pkg::*;

  load_info_t      info;
  logic [xlen-1:0] raw_data;
  logic            done;

  lsu_decode u_decode (
    .load_req (load_req),
    .info     (info)
  );

  lsu_execute u_execute (
    .clock    (clock),
    .reset    (reset),
    .flush    (flush),
    .fence    (fence),
    .info     (info),
    .ren      (load_req.ren),
    .store_in (store_req),
    .bus_rsp  (bus_rsp),
    .sq_ready (sq_ready),
    .rd_req   (bus_rd_req),
    .wr_req   (bus_wr_req),
    .raw_data (raw_data),
    .done     (done)
  );

  lsu_result u_result (
    .info     (info),
    .raw_data (raw_data),
    .done     (done),
    .load_rsp (load_rsp)
  );

endmodule

// ==== lsu_assert.sv ====
`timescale 1ns/1ns

module lsu_assert (
  input logic                     clock,
  input logic                     reset,
  input lsu_op_pkg::load_rsp_t    load_rsp,
  input lsu_bus_pkg::bus_rd_req_t rd_req,
  input lsu_bus_pkg::bus_wr_req_t wr_req,
  input lsu_bus_pkg::bus_rsp_t    bus_rsp
);

  // read request held until the data comes back
  ar_stable: assert property (@(posedge clock) disable iff (reset)
    rd_req.arvalid && !bus_rsp.rvalid |=> rd_req.arvalid && $stable(rd_req.araddr))
    else $error("arvalid or araddr changed before rvalid");

  aw_stable: assert property (@(posedge clock) disable iff (reset)
    wr_req.wvalid && !bus_rsp.wready |=> wr_req.wvalid && $stable(wr_req.waddr))
    else $error("wvalid or waddr changed before wready");

  rvalid_pulse: assert property (@(posedge clock) disable iff (reset)
    load_rsp.rvalid |=> !load_rsp.rvalid)
    else $error("load rvalid longer than one cycle");

endmodule

bind lsu_top lsu_assert u_assert (
  .clock    (clock),
  .reset    (reset),
  .load_rsp (load_rsp),
  .rd_req   (bus_rd_req),
  .wr_req   (bus_wr_req),
  .bus_rsp  (bus_rsp)
);

// ==== tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu;
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;

  localparam int n_random    = 400;
  localparam int n_ops       = n_random + 60;
  localparam int cycle_limit = 60 * n_ops;
  localparam int n_words     = 32;  // small window, forces cache conflicts

  logic clock;
  logic reset;
  logic flush;
  logic fence;
  load_req_t   load_req;
  store_req_t  store_req;
  bus_rsp_t    bus_rsp;
  load_rsp_t   load_rsp;
  logic        sq_ready;
  bus_rd_req_t bus_rd_req;
  bus_wr_req_t bus_wr_req;

  logic [31:0] sram[n_words];
  logic [7:0]  model[4*n_words];
  logic [31:0] dev_count;
  logic [31:0] got;
  logic        hold_rvalid;
  logic        hold_wready;
  logic        saw_ar;
  integer      seed;
  int          cycles;
  int          rd_wait;
  int          wr_wait;
  int          w;
  int          size;
  int          off;
  load_kind_t  kinds[5] = '{lb, lbu, lh, lhu, lw};
  load_kind_t  k;

  lsu_top DUT (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .fence      (fence),
    .load_req   (load_req),
    .store_req  (store_req),
    .bus_rsp    (bus_rsp),
    .load_rsp   (load_rsp),
    .sq_ready   (sq_ready),
    .bus_rd_req (bus_rd_req),
    .bus_wr_req (bus_wr_req)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (bus_rd_req.arvalid) begin
      saw_ar = 1'b1;
      check_value("bus_rd_req.rstrb", bus_rd_req.rstrb, read_strobe(load_req.op.ld.kind));
    end
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // bus slave, 0 to 5 cycles of delay per transfer
  always @(posedge clock) begin
    #1;
    bus_rsp.rvalid = 1'b0;
    bus_rsp.wready = 1'b0;
    if (bus_rd_req.arvalid && !hold_rvalid) begin
      if (rd_wait == 0) begin
        bus_rsp.rvalid = 1'b1;
        if (bus_rd_req.araddr >= dev_base) begin
          bus_rsp.rdata = dev_count;
          dev_count     = dev_count + 1;
        end else begin
          bus_rsp.rdata = sram[bus_rd_req.araddr[6:2]];
        end
        rd_wait = {$random(seed)} % 6;
      end else rd_wait = rd_wait - 1;
    end
    if (bus_wr_req.wvalid && !hold_wready) begin
      if (wr_wait == 0) begin
        bus_rsp.wready = 1'b1;
        for (int i = 0; i < 4; i++)
          if (bus_wr_req.wstrb[i])
            sram[bus_wr_req.waddr[6:2]][8*i +: 8] = bus_wr_req.wdata[8*i +: 8];
        wr_wait = {$random(seed)} % 6;
      end else wr_wait = wr_wait - 1;
    end
  end

  function automatic logic [31:0] fill_word(int idx);
    return (sram_base + 32'(idx) * 4) * 32'h9e37_79b1 ^ 32'h00a5_5a00;
  endfunction

  // expected load value from the byte model
  function automatic logic [31:0] expect_load(logic [31:0] a, load_kind_t kind);
    logic [31:0] word;
    logic [6:0]  wb;
    wb   = {a[6:2], 2'b00};
    word = {model[wb+3], model[wb+2], model[wb+1], model[wb]};
    word = word >> (8 * a[1:0]);
    case (kind)
      lb:      return {{24{word[7]}}, word[7:0]};
      lbu:     return {24'h0, word[7:0]};
      lh:      return {{16{word[15]}}, word[15:0]};
      lhu:     return {16'h0, word[15:0]};
      default: return word;
    endcase
  endfunction

  function automatic int pick_offset(int sz);
    if (sz == 2) return 0;
    if (sz == 1) return 2 * ({$random(seed)} % 2);
    return {$random(seed)} % 4;
  endfunction

  function automatic int kind_size(load_kind_t kind);
    if (kind == lw) return 2;
    if (kind == lh || kind == lhu) return 1;
    return 0;
  endfunction

  // one lane per byte read, from lane 0
  function automatic logic [3:0] read_strobe(load_kind_t kind);
    return 4'((32'd1 << (32'd1 << kind_size(kind))) - 1);
  endfunction

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_value(string name, logic [31:0] value, logic [31:0] expected);
    assert (value === expected) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, value, expected);
      $display("TB FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_true(logic cond, string msg);
    assert (cond) else fail_now(msg);
  endtask

  task automatic commit_store(logic [31:0] a, int sz, logic [31:0] data);
    logic [3:0] strb;
    strb = sz == 2 ? 4'b1111 : (sz == 1 ? 4'b0011 : 4'b0001) << a[1:0];
    while (!sq_ready) step();
    store_req.valid       = 1'b1;
    store_req.addr        = a;
    store_req.data        = data;
    store_req.op.st.spare = 1'b0;
    store_req.op.st.wstrb = strb;
    for (int i = 0; i < 4; i++)
      if (strb[i]) model[{a[6:2], 2'(i)}] = data[8*i +: 8];
    step();
    store_req.valid = 1'b0;
  endtask

  task automatic issue_load(logic [31:0] a, load_kind_t kind, output logic [31:0] data);
    load_req.ren        = 1'b1;
    load_req.addr       = a;
    load_req.op.ld.kind = kind;
    saw_ar              = 1'b0;
    do step(); while (!load_rsp.rvalid);
    data         = load_rsp.rdata;
    load_req.ren = 1'b0;
  endtask

  task automatic load_and_check(logic [31:0] a, load_kind_t kind);
    logic [31:0] data;
    issue_load(a, kind, data);
    check_value("load_rsp.rdata", data, expect_load(a, kind));
  endtask

  // queue is empty once wvalid stays low past a recover cycle
  task automatic wait_drained();
    int idle;
    idle = 0;
    while (idle < 3) begin
      step();
      idle = bus_wr_req.wvalid ? 0 : idle + 1;
    end
  endtask

  task automatic pulse_fence();
    fence = 1'b1;
    step();
    fence = 1'b0;
  endtask

  initial begin
    seed        = 88;
    cycles      = 0;
    rd_wait     = 0;
    wr_wait     = 0;
    dev_count   = '0;
    reset       = 1'b1;
    flush       = 1'b0;
    fence       = 1'b0;
    load_req    = '0;
    store_req   = '0;
    bus_rsp     = '0;
    hold_rvalid = 1'b0;
    hold_wready = 1'b0;
    saw_ar      = 1'b0;
    for (int i = 0; i < n_words; i++) begin
      sram[i] = fill_word(i);
      for (int j = 0; j < 4; j++) model[4*i+j] = sram[i][8*j +: 8];
    end
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;

    // every kind at every legal offset
    for (int o = 0; o < 4; o++)
      for (int i = 0; i < 5; i++)
        if (o % (1 << kind_size(kinds[i])) == 0)
          load_and_check(sram_base + 32'(4 * (3 + o) + o), kinds[i]);

    for (int n = 0; n < n_random; n++) begin
      w = {$random(seed)} % n_words;
      if ($random(seed) & 1) begin
        size = {$random(seed)} % 3;
        off  = pick_offset(size);
        commit_store(sram_base + 32'(4 * w + off), size, $random(seed));
      end else begin
        k   = kinds[{$random(seed)} % 5];
        off = pick_offset(kind_size(k));
        load_and_check(sram_base + 32'(4 * w + off), k);
      end
    end

    // queue full with wready held back
    wait_drained();
    hold_wready = 1'b1;
    for (int i = 0; i < 4; i++) commit_store(sram_base + 32'(4 * (20 + i)), 2, $random(seed));
    check_true(!sq_ready, "sq_ready stayed high with four stores queued");
    hold_wready = 1'b0;
    while (!sq_ready) step();
    load_and_check(sram_base + 32'(4 * 21), lw);

    // device reads must never be cached
    issue_load(dev_base, lw, got);
    check_value("device rdata", got, 32'd0);
    issue_load(dev_base, lw, got);
    check_value("device rdata", got, 32'd1);

    wait_drained();
    load_and_check(sram_base + 32'(4 * 7), lw);
    load_and_check(sram_base + 32'(4 * 7), lw);
    check_true(!saw_ar, "a cached sram load went to the bus");
    pulse_fence();
    load_and_check(sram_base + 32'(4 * 7), lw);
    check_true(saw_ar, "no bus read for an sram load after a fence");

    // flush while the bus read is outstanding
    pulse_fence();
    hold_rvalid         = 1'b1;
    load_req.ren        = 1'b1;
    load_req.addr       = sram_base + 32'(4 * 9);
    load_req.op.ld.kind = lw;
    do step(); while (!bus_rd_req.arvalid);
    flush        = 1'b1;
    load_req.ren = 1'b0;
    step();
    flush       = 1'b0;
    hold_rvalid = 1'b0;
    repeat (10) begin
      step();
      check_true(!load_rsp.rvalid, "a flushed load still returned rvalid");
    end
    load_and_check(sram_base + 32'(4 * 9), lhu);

    issue_load(32'h2000_0000, lw, got);
    check_value("invalid rdata", got, 32'd0);
    check_true(!saw_ar, "a load to an invalid address reached the bus");

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
lsu_bus_pkg.sv
lsu_op_pkg.sv
lsu_decode.sv
lsu_store_queue.sv
lsu_l1d.sv
lsu_execute.sv
lsu_result.sv
lsu_top.sv
lsu_assert.sv
tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
RTL_TOP   ?= lsu_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
